//--- Makefile
TOP = instructionControlTb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- all.f
verilog/controlPkg.sv
verilog/mainDecoder.sv
verilog/aluDecoder.sv
verilog/branchResolver.sv
verilog/controlPipeline.sv
verilog/instructionControl.sv
verification/controlPipeline_asserts.sv
verification/instructionControlTb.sv

//--- verification/controlPipeline_asserts.sv
`timescale 1ns/10ps

module controlPipeline_asserts import controlPkg::*; (
    input logic  clock,
    input logic  reset,
    input aluOpT exAluOp,
    input logic  exAluSrcImm,
    input logic  exRegDst,
    input logic  exMovn,
    input logic  exMovz,
    input logic  exLink,
    input logic  memRead,
    input logic  memWrite,
    input logic  memByte,
    input logic  memHalf,
    input logic  memSignExtend,
    input logic  memRegWrite,
    input logic  memToReg
);

    logic anyActive;

    assign anyActive = exAluSrcImm | exRegDst | exMovn | exMovz | exLink | memRead | memWrite
                     | memByte | memHalf | memSignExtend | memRegWrite | memToReg;

    // A single access per instruction
    memAccessExclusive: assert property (@(posedge clock) disable iff (reset)
        !(memRead && memWrite))
        else $error("memRead and memWrite are high together");

    movExclusive: assert property (@(posedge clock) disable iff (reset) !(exMovn && exMovz))
        else $error("exMovn and exMovz are high together");

    // Both registers come out of reset idle
    idleAfterReset: assert property (@(posedge clock)
        reset |=> (exAluOp == aluAddu && !anyActive))
        else $error("registered control is not idle after reset");

endmodule

bind controlPipeline controlPipeline_asserts u_controlPipelineAsserts (
    .clock         (clock),
    .reset         (reset),
    .exAluOp       (exAluOp),
    .exAluSrcImm   (exAluSrcImm),
    .exRegDst      (exRegDst),
    .exMovn        (exMovn),
    .exMovz        (exMovz),
    .exLink        (exLink),
    .memRead       (memRead),
    .memWrite      (memWrite),
    .memByte       (memByte),
    .memHalf       (memHalf),
    .memSignExtend (memSignExtend),
    .memRegWrite   (memRegWrite),
    .memToReg      (memToReg)
);

//--- verification/instructionControlTb.sv
`timescale 1ns/10ps

module instructionControlTb import controlPkg::*; ();

    localparam int clockPeriod = 40;
    localparam int numRandom   = 400;
    // Reset, directed list, load/store and stall pairs, random run, drain
    localparam int numPlanned  = 5 + 46 + 5 + numRandom + 3;

    typedef struct packed {
        pcSrcT pcSrc;
        logic  link;
        logic  signExtend;
        logic  nextIsDelay;
        aluOpT aluOp;
        logic  aluSrcImm;
        logic  regDst;
        logic  movn;
        logic  movz;
        logic  memRead;
        logic  memWrite;
        logic  memByte;
        logic  memHalf;
        logic  memSignExtend;
        logic  regWrite;
        logic  memToReg;
    } ctrlT;

    // addu and pcNext both encode as zero
    localparam ctrlT idleControl = '0;

    logic               clock = 1'b0;
    logic               reset;
    logic               stall;
    logic [opcodeW-1:0] opCode;
    logic [functW-1:0]  funct;
    logic [regW-1:0]    rt;
    logic               cmpEq, cmpGz, cmpGez, cmpLz, cmpLez;

    pcSrcT pcSrc;
    aluOpT exAluOp;
    logic  link, signExtend, nextIsDelay;
    logic  exAluSrcImm, exRegDst, exMovn, exMovz, exLink;
    logic  memRead, memWrite, memByte, memHalf, memSignExtend, memRegWrite, memToReg;

    integer      seed = 2;
    int          checkCount = 0;
    int          errorCount = 0;
    logic [16:0] keptList[$];
    ctrlT        exQueue[$];
    ctrlT        prevEx = idleControl;

    instructionControl u_dut (.*);

    always #(clockPeriod / 2) clock = ~clock;

    function automatic aluOpT rTypeAluOp(input logic [5:0] fn);
        case (fn)
            fnAdd:   return aluAdd;
            fnAddu:  return aluAddu;
            fnSub:   return aluSub;
            fnSubu:  return aluSubu;
            fnAnd:   return aluAnd;
            fnOr:    return aluOr;
            fnXor:   return aluXor;
            fnNor:   return aluNor;
            fnSlt:   return aluSlt;
            fnSltu:  return aluSltu;
            fnSll:   return aluSll;
            fnSrl:   return aluSrl;
            fnSra:   return aluSra;
            fnSllv:  return aluSllv;
            fnSrlv:  return aluSrlv;
            fnSrav:  return aluSrav;
            default: return aluAddu;
        endcase
    endfunction

    // Full control of one instruction; regWrite includes the link forms
    function automatic ctrlT expectedControl(input logic [5:0] opc, input logic [5:0] fn,
                                             input logic [4:0] rtv, input logic [4:0] flags);
        ctrlT c;
        logic eq, gz, gez, lz, lez;
        logic condition;
        {eq, gz, gez, lz, lez} = flags;
        c = idleControl;
        c.signExtend = 1'b1;
        condition = 1'b0;
        case (opc)
            opSpecial: begin
                c.aluOp = rTypeAluOp(fn);
                if (c.aluOp != aluAddu || fn == fnAddu || fn == fnMovn || fn == fnMovz) begin
                    c.regDst   = 1'b1;
                    c.regWrite = 1'b1;
                    c.movn     = (fn == fnMovn);
                    c.movz     = (fn == fnMovz);
                end else if (fn == fnJr || fn == fnJalr) begin
                    c.pcSrc       = pcJumpReg;
                    c.nextIsDelay = 1'b1;
                    c.link        = (fn == fnJalr);
                    c.regDst      = c.link;
                    c.regWrite    = c.link;
                end
            end
            opJ, opJal: begin
                c.pcSrc       = pcJumpImm;
                c.nextIsDelay = 1'b1;
                c.link        = (opc == opJal);
                c.regWrite    = c.link;
            end
            opBeq, opBne, opBlez, opBgtz: begin
                c.nextIsDelay = 1'b1;
                if (opc == opBeq) condition = eq;
                else if (opc == opBne) condition = !eq;
                else if (opc == opBlez) condition = lez;
                else condition = gz;
            end
            opRegimm: begin
                if (rtv inside {rtBltz, rtBgez, rtBltzal, rtBgezal}) begin
                    c.nextIsDelay = 1'b1;
                    // rt bit 0 picks gez over lz, bit 4 marks the link form
                    condition  = rtv[0] ? gez : lz;
                    c.link     = rtv[4];
                    c.regWrite = rtv[4];
                end
            end
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                c.aluSrcImm  = 1'b1;
                c.regWrite   = 1'b1;
                c.signExtend = !(opc inside {opAndi, opOri, opXori, opLui});
                case (opc)
                    opAddi:  c.aluOp = aluAdd;
                    opSlti:  c.aluOp = aluSlt;
                    opSltiu: c.aluOp = aluSltu;
                    opAndi:  c.aluOp = aluAnd;
                    opOri:   c.aluOp = aluOr;
                    opXori:  c.aluOp = aluXor;
                    opLui:   c.aluOp = aluSllc;
                    default: c.aluOp = aluAddu;
                endcase
            end
            opLb, opLh, opLw, opLbu, opLhu: begin
                c.aluSrcImm     = 1'b1;
                c.memRead       = 1'b1;
                c.regWrite      = 1'b1;
                c.memToReg      = 1'b1;
                c.memByte       = opc inside {opLb, opLbu};
                c.memHalf       = opc inside {opLh, opLhu};
                c.memSignExtend = opc inside {opLb, opLh};
            end
            opSb, opSh, opSw: begin
                c.aluSrcImm = 1'b1;
                c.memWrite  = 1'b1;
                c.memByte   = (opc == opSb);
                c.memHalf   = (opc == opSh);
            end
            default: ;
        endcase
        if (condition) c.pcSrc = pcBranch;
        return c;
    endfunction

    // Packed as {opcode, funct, rt}
    task automatic buildKeptList();
        logic [5:0] rFn [20];
        logic [5:0] iOp [22];
        logic [4:0] bRt [4];
        rFn = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu,
                fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav, fnJr, fnJalr, fnMovn, fnMovz};
        iOp = '{opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui, opJ, opJal,
                opBeq, opBne, opBlez, opBgtz, opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw};
        bRt = '{rtBltz, rtBgez, rtBltzal, rtBgezal};
        foreach (rFn[i]) keptList.push_back({opSpecial, rFn[i], 5'd0});
        foreach (iOp[i]) keptList.push_back({iOp[i], 6'd0, 5'd0});
        foreach (bRt[i]) keptList.push_back({opRegimm, 6'd0, bRt[i]});
    endtask

    function automatic logic [16:0] illegalInstruction(input logic [31:0] r,
                                                       input logic [31:0] fill);
        logic [5:0] badOp [4];
        logic [5:0] badFn [4];
        logic [4:0] badRt [4];
        // cop0, special2, lwl, ll
        badOp = '{6'h10, 6'h1c, 6'h22, 6'h30};
        // syscall, break, mult, mfhi
        badFn = '{6'h0c, 6'h0d, 6'h18, 6'h10};
        // Branch-likely and trap rt codes
        badRt = '{5'h02, 5'h03, 5'h0c, 5'h12};
        case (r[5:4])
            2'd0:    return {badOp[r[9:8]], fill[10:0]};
            2'd1:    return {opSpecial, badFn[r[9:8]], fill[4:0]};
            2'd2:    return {opRegimm, fill[5:0], badRt[r[9:8]]};
            default: return {6'h3f, fill[10:0]};
        endcase
    endfunction

    task automatic presentInstruction(input logic [5:0] opc, input logic [5:0] fn,
                                      input logic [4:0] rtv, input logic stallIn);
        logic [31:0] r;
        r = $random(seed);
        @(negedge clock);
        opCode <= opc;
        funct  <= fn;
        rt     <= rtv;
        stall  <= stallIn;
        {cmpEq, cmpGz, cmpGez, cmpLz, cmpLez} <= r[4:0];
    endtask

    task automatic compareValue(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // Inputs change by nonblocking assignment, so this edge still sees the old ones
    always @(negedge clock) begin
        ctrlT cur;
        ctrlT exExp;
        ctrlT memExp;
        cur   = expectedControl(opCode, funct, rt, {cmpEq, cmpGz, cmpGez, cmpLz, cmpLez});
        exExp = (reset || stall) ? idleControl : cur;
        exQueue.push_back(exExp);
        if (exQueue.size() > 1) prevEx = exQueue.pop_front();
        memExp = reset ? idleControl : prevEx;

        compareValue("pcSrc", 8'(pcSrc), 8'(cur.pcSrc));
        compareValue("link", 8'(link), 8'(cur.link));
        compareValue("signExtend", 8'(signExtend), 8'(cur.signExtend));
        compareValue("nextIsDelay", 8'(nextIsDelay), 8'(cur.nextIsDelay));

        compareValue("exAluOp", 8'(exAluOp), 8'(exExp.aluOp));
        compareValue("exAluSrcImm", 8'(exAluSrcImm), 8'(exExp.aluSrcImm));
        compareValue("exRegDst", 8'(exRegDst), 8'(exExp.regDst));
        compareValue("exMovn", 8'(exMovn), 8'(exExp.movn));
        compareValue("exMovz", 8'(exMovz), 8'(exExp.movz));
        compareValue("exLink", 8'(exLink), 8'(exExp.link));

        compareValue("memRead", 8'(memRead), 8'(memExp.memRead));
        compareValue("memWrite", 8'(memWrite), 8'(memExp.memWrite));
        compareValue("memByte", 8'(memByte), 8'(memExp.memByte));
        compareValue("memHalf", 8'(memHalf), 8'(memExp.memHalf));
        compareValue("memSignExtend", 8'(memSignExtend), 8'(memExp.memSignExtend));
        compareValue("memRegWrite", 8'(memRegWrite), 8'(memExp.regWrite));
        compareValue("memToReg", 8'(memToReg), 8'(memExp.memToReg));
    end

    initial begin
        logic [31:0] r;
        logic [31:0] fill;
        logic [16:0] instr;
        int          idx;
        reset  = 1'b1;
        stall  = 1'b0;
        opCode = opSpecial;
        funct  = fnSll;
        rt     = '0;
        {cmpEq, cmpGz, cmpGez, cmpLz, cmpLez} = '0;
        buildKeptList();
        repeat (5) @(negedge clock);
        reset <= 1'b0;

        // Every kept instruction once, no stall
        foreach (keptList[i]) begin
            presentInstruction(keptList[i][16:11], keptList[i][10:5], keptList[i][4:0], 1'b0);
        end

        // Load then store back to back
        presentInstruction(opLw, 6'h00, 5'h04, 1'b0);
        presentInstruction(opSw, 6'h00, 5'h04, 1'b0);
        // Stalled load between a store and an add
        presentInstruction(opSb, 6'h00, 5'h02, 1'b0);
        presentInstruction(opLhu, 6'h00, 5'h02, 1'b1);
        presentInstruction(opSpecial, fnAdd, 5'h03, 1'b0);

        for (int i = 0; i < numRandom; i++) begin
            r    = $random(seed);
            fill = $random(seed);
            if (r[2:0] == 3'd0) begin
                instr = illegalInstruction(r, fill);
            end else begin
                idx   = int'(r[15:8]) % keptList.size();
                instr = keptList[idx];
                // Fields the opcode ignores get random bits
                if (instr[16:11] != opSpecial) instr[10:5] = fill[5:0];
                if (instr[16:11] != opRegimm) instr[4:0] = fill[10:6];
            end
            presentInstruction(instr[16:11], instr[10:5], instr[4:0], r[31:30] == 2'b11);
        end

        repeat (3) presentInstruction(opSpecial, fnSll, 5'h00, 1'b0);
        @(posedge clock);
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(numPlanned * clockPeriod * 3 / 2);
        $display("Timeout: the run did not finish within the expected number of cycles");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- verilog/aluDecoder.sv
`timescale 1ns/10ps

module aluDecoder import controlPkg::*; (
    input  opcodeT opCode,
    input  functT  funct,
    output aluOpT  aluOp
);

    always_comb begin
        case (opCode)
            opSpecial: begin
                case (funct)
                    fnAdd:   aluOp = aluAdd;
                    fnAddu:  aluOp = aluAddu;
                    fnSub:   aluOp = aluSub;
                    fnSubu:  aluOp = aluSubu;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnNor:   aluOp = aluNor;
                    fnSlt:   aluOp = aluSlt;
                    fnSltu:  aluOp = aluSltu;
                    fnSll:   aluOp = aluSll;
                    fnSrl:   aluOp = aluSrl;
                    fnSra:   aluOp = aluSra;
                    fnSllv:  aluOp = aluSllv;
                    fnSrlv:  aluOp = aluSrlv;
                    fnSrav:  aluOp = aluSrav;
                    // jr, jalr, movn and movz pass rs through
                    default: aluOp = aluAddu;
                endcase
            end
            opAddi:  aluOp = aluAdd;
            opAddiu: aluOp = aluAddu;
            opSlti:  aluOp = aluSlt;
            opSltiu: aluOp = aluSltu;
            opAndi:  aluOp = aluAnd;
            opOri:   aluOp = aluOr;
            opXori:  aluOp = aluXor;
            // Immediate shifted into the upper half
            opLui:   aluOp = aluSllc;
            // Address generation for loads and stores, nothing useful for the rest
            default: aluOp = aluAddu;
        endcase
    end

endmodule

//--- verilog/branchResolver.sv
`timescale 1ns/10ps

module branchResolver import controlPkg::*; (
    input  opcodeT opCode,
    input  regimmT rt,
    input  logic   isBranch,
    input  logic   isJump,
    input  logic   jumpReg,
    input  logic   cmpEq,
    input  logic   cmpGz,
    input  logic   cmpGez,
    input  logic   cmpLz,
    input  logic   cmpLez,
    output pcSrcT  pcSrc,
    output logic   branchLink,
    output logic   nextIsDelay
);

    logic taken;
    logic knownBranch;

    always_comb begin
        taken       = 1'b0;
        knownBranch = 1'b1;
        case (opCode)
            opBeq:  taken = cmpEq;
            opBne:  taken = ~cmpEq;
            opBlez: taken = cmpLez;
            opBgtz: taken = cmpGz;
            opRegimm: begin
                case (rt)
                    rtBltz, rtBltzal: taken = cmpLz;
                    rtBgez, rtBgezal: taken = cmpGez;
                    // Unused rt codes are not branches
                    default: knownBranch = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    // Link is written even when the branch falls through
    assign branchLink = isBranch && (opCode == opRegimm) && ((rt == rtBltzal) || (rt == rtBgezal));

    always_comb begin
        if (isJump) begin
            pcSrc = jumpReg ? pcJumpReg : pcJumpImm;
        end else if (isBranch && knownBranch && taken) begin
            pcSrc = pcBranch;
        end else begin
            pcSrc = pcNext;
        end
    end

    assign nextIsDelay = isJump | (isBranch & knownBranch);

endmodule

//--- verilog/controlPipeline.sv
`timescale 1ns/10ps

module controlPipeline import controlPkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  stall,
    input  aluOpT idAluOp,
    input  logic  idAluSrcImm,
    input  logic  idRegDst,
    input  logic  idLink,
    input  logic  idMovn,
    input  logic  idMovz,
    input  logic  idMemRead,
    input  logic  idMemWrite,
    input  logic  idMemByte,
    input  logic  idMemHalf,
    input  logic  idMemSignExtend,
    input  logic  idRegWrite,
    input  logic  idMemToReg,
    output aluOpT exAluOp,
    output logic  exAluSrcImm,
    output logic  exRegDst,
    output logic  exMovn,
    output logic  exMovz,
    output logic  exLink,
    output logic  memRead,
    output logic  memWrite,
    output logic  memByte,
    output logic  memHalf,
    output logic  memSignExtend,
    output logic  memRegWrite,
    output logic  memToReg
);

    // Memory and writeback bits waiting in EX
    logic [6:0] exMemBits;

    // ID/EX: a stall turns the incoming instruction into a bubble
    always_ff @(posedge clock) begin
        if (reset || stall) begin
            exAluOp     <= aluAddu;
            exAluSrcImm <= 1'b0;
            exRegDst    <= 1'b0;
            exMovn      <= 1'b0;
            exMovz      <= 1'b0;
            exLink      <= 1'b0;
            exMemBits   <= '0;
        end else begin
            exAluOp     <= idAluOp;
            exAluSrcImm <= idAluSrcImm;
            exRegDst    <= idRegDst;
            exMovn      <= idMovn;
            exMovz      <= idMovz;
            exLink      <= idLink;
            // Every link form writes its return address
            exMemBits   <= {idMemRead, idMemWrite, idMemByte, idMemHalf,
                            idMemSignExtend, idRegWrite | idLink, idMemToReg};
        end
    end

    // EX/MEM advances regardless of stall
    always_ff @(posedge clock) begin
        if (reset) begin
            {memRead, memWrite, memByte, memHalf, memSignExtend, memRegWrite, memToReg} <= '0;
        end else begin
            {memRead, memWrite, memByte, memHalf, memSignExtend, memRegWrite, memToReg} <=
                exMemBits;
        end
    end

endmodule

//--- verilog/controlPkg.sv
package controlPkg;

    // MIPS32 instruction field widths
    localparam int opcodeW = 6;
    localparam int functW  = 6;
    localparam int regW    = 5;

    // Primary opcodes handled by the decoder
    typedef enum logic [opcodeW-1:0] {
        opSpecial = 6'h00,
        opRegimm  = 6'h01,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opBlez    = 6'h06,
        opBgtz    = 6'h07,
        opAddi    = 6'h08,
        opAddiu   = 6'h09,
        opSlti    = 6'h0a,
        opSltiu   = 6'h0b,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opXori    = 6'h0e,
        opLui     = 6'h0f,
        opLb      = 6'h20,
        opLh      = 6'h21,
        opLw      = 6'h23,
        opLbu     = 6'h24,
        opLhu     = 6'h25,
        opSb      = 6'h28,
        opSh      = 6'h29,
        opSw      = 6'h2b
    } opcodeT;

    // R-type function codes
    typedef enum logic [functW-1:0] {
        fnSll  = 6'h00,
        fnSrl  = 6'h02,
        fnSra  = 6'h03,
        fnSllv = 6'h04,
        fnSrlv = 6'h06,
        fnSrav = 6'h07,
        fnJr   = 6'h08,
        fnJalr = 6'h09,
        fnMovz = 6'h0a,
        fnMovn = 6'h0b,
        fnAdd  = 6'h20,
        fnAddu = 6'h21,
        fnSub  = 6'h22,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnNor  = 6'h27,
        fnSlt  = 6'h2a,
        fnSltu = 6'h2b
    } functT;

    // REGIMM branches, selected by the rt field
    typedef enum logic [regW-1:0] {
        rtBltz   = 5'h00,
        rtBgez   = 5'h01,
        rtBltzal = 5'h10,
        rtBgezal = 5'h11
    } regimmT;

    // ALU operations; addu doubles as the idle operation
    typedef enum logic [4:0] {
        aluAddu, aluAdd, aluSub, aluSubu,
        aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu,
        aluSll, aluSrl, aluSra,
        aluSllv, aluSrlv, aluSrav,
        aluSllc
    } aluOpT;

    // Next-PC source select
    typedef enum logic [1:0] {
        pcNext    = 2'd0,
        pcJumpReg = 2'd1,
        pcJumpImm = 2'd2,
        pcBranch  = 2'd3
    } pcSrcT;

endpackage

//--- verilog/instructionControl.sv
`timescale 1ns/10ps

module instructionControl import controlPkg::*; (
    input  logic               clock,
    input  logic               reset,
    input  logic               stall,
    input  logic [opcodeW-1:0] opCode,
    input  logic [functW-1:0]  funct,
    input  logic [regW-1:0]    rt,
    input  logic               cmpEq,
    input  logic               cmpGz,
    input  logic               cmpGez,
    input  logic               cmpLz,
    input  logic               cmpLez,
    output pcSrcT              pcSrc,
    output logic               link,
    output logic               signExtend,
    output logic               nextIsDelay,
    output aluOpT              exAluOp,
    output logic               exAluSrcImm,
    output logic               exRegDst,
    output logic               exMovn,
    output logic               exMovz,
    output logic               exLink,
    output logic               memRead,
    output logic               memWrite,
    output logic               memByte,
    output logic               memHalf,
    output logic               memSignExtend,
    output logic               memRegWrite,
    output logic               memToReg
);

    // ID-stage control
    aluOpT idAluOp;
    logic  idAluSrcImm, idRegDst, idLink, idMovn, idMovz;
    logic  idMemRead, idMemWrite, idMemByte, idMemHalf, idMemSignExtend;
    logic  idRegWrite, idMemToReg;
    logic  isBranch, isJump, jumpReg;
    logic  branchLink;

    mainDecoder u_mainDecoder (
        .opCode        (opcodeT'(opCode)),
        .funct         (functT'(funct)),
        .aluSrcImm     (idAluSrcImm),
        .regDst        (idRegDst),
        .link          (idLink),
        .movn          (idMovn),
        .movz          (idMovz),
        .memRead       (idMemRead),
        .memWrite      (idMemWrite),
        .memByte       (idMemByte),
        .memHalf       (idMemHalf),
        .memSignExtend (idMemSignExtend),
        .regWrite      (idRegWrite),
        .memToReg      (idMemToReg),
        .isBranch      (isBranch),
        .isJump        (isJump),
        .jumpReg       (jumpReg),
        .signExtend    (signExtend)
    );

    aluDecoder u_aluDecoder (
        .opCode (opcodeT'(opCode)),
        .funct  (functT'(funct)),
        .aluOp  (idAluOp)
    );

    branchResolver u_branchResolver (
        .opCode      (opcodeT'(opCode)),
        .rt          (regimmT'(rt)),
        .isBranch    (isBranch),
        .isJump      (isJump),
        .jumpReg     (jumpReg),
        .cmpEq       (cmpEq),
        .cmpGz       (cmpGz),
        .cmpGez      (cmpGez),
        .cmpLz       (cmpLz),
        .cmpLez      (cmpLez),
        .pcSrc       (pcSrc),
        .branchLink  (branchLink),
        .nextIsDelay (nextIsDelay)
    );

    // jal and jalr from the decoder, bltzal and bgezal from the resolver
    assign link = idLink | branchLink;

    controlPipeline u_controlPipeline (
        .clock           (clock),
        .reset           (reset),
        .stall           (stall),
        .idAluOp         (idAluOp),
        .idAluSrcImm     (idAluSrcImm),
        .idRegDst        (idRegDst),
        .idLink          (link),
        .idMovn          (idMovn),
        .idMovz          (idMovz),
        .idMemRead       (idMemRead),
        .idMemWrite      (idMemWrite),
        .idMemByte       (idMemByte),
        .idMemHalf       (idMemHalf),
        .idMemSignExtend (idMemSignExtend),
        .idRegWrite      (idRegWrite),
        .idMemToReg      (idMemToReg),
        .exAluOp         (exAluOp),
        .exAluSrcImm     (exAluSrcImm),
        .exRegDst        (exRegDst),
        .exMovn          (exMovn),
        .exMovz          (exMovz),
        .exLink          (exLink),
        .memRead         (memRead),
        .memWrite        (memWrite),
        .memByte         (memByte),
        .memHalf         (memHalf),
        .memSignExtend   (memSignExtend),
        .memRegWrite     (memRegWrite),
        .memToReg        (memToReg)
    );

endmodule

//--- verilog/mainDecoder.sv
`timescale 1ns/10ps

module mainDecoder import controlPkg::*; (
    input  opcodeT opCode,
    input  functT  funct,
    output logic   aluSrcImm,
    output logic   regDst,
    output logic   link,
    output logic   movn,
    output logic   movz,
    output logic   memRead,
    output logic   memWrite,
    output logic   memByte,
    output logic   memHalf,
    output logic   memSignExtend,
    output logic   regWrite,
    output logic   memToReg,
    output logic   isBranch,
    output logic   isJump,
    output logic   jumpReg,
    output logic   signExtend
);

    always_comb begin
        // Everything idle unless the opcode says otherwise
        aluSrcImm     = 1'b0;
        regDst        = 1'b0;
        link          = 1'b0;
        movn          = 1'b0;
        movz          = 1'b0;
        memRead       = 1'b0;
        memWrite      = 1'b0;
        memByte       = 1'b0;
        memHalf       = 1'b0;
        memSignExtend = 1'b0;
        regWrite      = 1'b0;
        memToReg      = 1'b0;
        isBranch      = 1'b0;
        isJump        = 1'b0;
        jumpReg       = 1'b0;
        signExtend    = 1'b1;

        case (opCode)
            opSpecial: begin
                case (funct)
                    fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor,
                    fnSlt, fnSltu, fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav: begin
                        regDst   = 1'b1;
                        regWrite = 1'b1;
                    end
                    fnJr: begin
                        isJump  = 1'b1;
                        jumpReg = 1'b1;
                    end
                    // Return address goes to rd
                    fnJalr: begin
                        isJump   = 1'b1;
                        jumpReg  = 1'b1;
                        link     = 1'b1;
                        regDst   = 1'b1;
                        regWrite = 1'b1;
                    end
                    fnMovn, fnMovz: begin
                        regDst   = 1'b1;
                        regWrite = 1'b1;
                        movn     = (funct == fnMovn);
                        movz     = (funct == fnMovz);
                    end
                    default: ;
                endcase
            end
            opAddi, opAddiu, opSlti, opSltiu: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            // Logical immediates are zero extended
            opAndi, opOri, opXori, opLui: begin
                aluSrcImm  = 1'b1;
                regWrite   = 1'b1;
                signExtend = 1'b0;
            end
            opJ: isJump = 1'b1;
            opJal: begin
                isJump   = 1'b1;
                link     = 1'b1;
                regWrite = 1'b1;
            end
            opBeq, opBne, opBlez, opBgtz, opRegimm: isBranch = 1'b1;
            opLb, opLh, opLw, opLbu, opLhu: begin
                aluSrcImm     = 1'b1;
                memRead       = 1'b1;
                regWrite      = 1'b1;
                memToReg      = 1'b1;
                memByte       = (opCode == opLb) || (opCode == opLbu);
                memHalf       = (opCode == opLh) || (opCode == opLhu);
                memSignExtend = (opCode == opLb) || (opCode == opLh);
            end
            opSb, opSh, opSw: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
                memByte   = (opCode == opSb);
                memHalf   = (opCode == opSh);
            end
            default: ;
        endcase
    end

endmodule
